//--- vlog.f
hw/exPkg.sv
hw/instrDecode.sv
hw/operandForward.sv
hw/aluExecute.sv
hw/exResultRegister.sv
hw/exStage.sv
testbench/exStageTb.sv

//--- Bender.yml
package:
  name: exStage

sources:
  - hw/exPkg.sv
  - hw/instrDecode.sv
  - hw/operandForward.sv
  - hw/aluExecute.sv
  - hw/exResultRegister.sv
  - hw/exStage.sv
  - target: simulation
    files:
      - testbench/exStageTb.sv

//--- testbench/exStageTb.sv
/*
 * Testbench for the execute stage
 * Random stimulus, reference rules and checking assertions
 */

module exStageTb import exPkg::*; ();

    localparam int WAIT_LIMIT = 10;

    logic    clk;
    logic    arstN;
    logic    stall;
    logic    clr;
    instrT   instrEx;
    wordT    pcEx;
    wordT    dataRsEx;
    wordT    dataRtEx;
    imm16T   imm16Ex;
    shamtT   shamtEx;
    regAddrT addrRsEx;
    regAddrT addrRtEx;
    regAddrT regWriteAddrEx;
    wordT    regWriteDataEx;
    tnewT    tnewEx;
    regAddrT regAddrMem;
    wordT    regDataMem;
    regAddrT regAddrWb;
    wordT    regDataWb;
    instrT   instrMem;
    wordT    pcMem;
    wordT    aluOutMem;
    wordT    memWriteDataMem;
    regAddrT addrRtMem;
    regAddrT regWriteAddrMem;
    wordT    regWriteDataMem;
    tnewT    tnewMem;

    // Expected contents of the EX/MEM register
    instrT   expInstr;
    wordT    expPc;
    wordT    expAlu;
    wordT    expStore;
    wordT    expWbData;
    regAddrT expAddrRt;
    regAddrT expWbAddr;
    tnewT    expTnew;
    wordT    fwdRs;
    wordT    fwdRt;
    wordT    aluRef;

    string testName;
    int    errorCount;
    int    testsPassed;
    int    testsFailed;
    wordT  nextPc;
    wordT  lastPc;

    exStage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic wordT signExt16(input imm16T imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Newest producer first, register 0 never bypassed
    function automatic wordT forwardValue(input regAddrT addr, input wordT data);
        if (addr != '0 && addr == regAddrMem)
            return regDataMem;
        if (addr != '0 && addr == regAddrWb)
            return regDataWb;
        return data;
    endfunction

    function automatic bit isCalc(input instrT instr);
        return instr inside {[ADD:SRAV], [ADDI:LUI]};
    endfunction

    function automatic wordT expectAlu(input instrT instr, input wordT a, input wordT b,
                                       input imm16T imm, input shamtT sh);
        wordT sImm;
        wordT zImm;
        sImm = signExt16(imm);
        zImm = {16'h0000, imm};
        case (instr)
            ADD, ADDU:           return a + b;
            SUB, SUBU:           return a - b;
            AND:                 return a & b;
            OR:                  return a | b;
            XOR:                 return a ^ b;
            NOR:                 return ~(a | b);
            SLT:                 return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:                return (a < b) ? 32'd1 : 32'd0;
            SLL:                 return b << sh;
            SRL:                 return b >> sh;
            SRA:                 return $signed(b) >>> sh;
            SLLV:                return b << a[4:0];
            SRLV:                return b >> a[4:0];
            SRAV:                return $signed(b) >>> a[4:0];
            ADDI, ADDIU, LW, SW: return a + sImm;
            ANDI:                return a & zImm;
            ORI:                 return a | zImm;
            XORI:                return a ^ zImm;
            SLTI:                return ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            SLTIU:               return (a < sImm) ? 32'd1 : 32'd0;
            LUI:                 return {imm, 16'h0000};
            default:             return '0;
        endcase
    endfunction

    // Reference model of the stage, captured on the same edges as the DUT
    always @(posedge clk or negedge arstN) begin
        if (!arstN || clr) begin
            expInstr  <= NOP;
            expPc     <= '0;
            expAlu    <= '0;
            expStore  <= '0;
            expWbData <= '0;
            expAddrRt <= '0;
            expWbAddr <= '0;
            expTnew   <= '0;
        end else if (!stall) begin
            fwdRs = forwardValue(addrRsEx, dataRsEx);
            fwdRt = forwardValue(addrRtEx, dataRtEx);
            aluRef = expectAlu(instrEx, fwdRs, fwdRt, imm16Ex, shamtEx);
            expInstr  <= instrEx;
            expPc     <= pcEx;
            expAlu    <= aluRef;
            expStore  <= fwdRt;
            expWbData <= isCalc(instrEx) ? aluRef : regWriteDataEx;
            expAddrRt <= addrRtEx;
            expWbAddr <= regWriteAddrEx;
            expTnew   <= (tnewEx == '0) ? '0 : tnewT'(tnewEx - 1);
        end
    end

    task automatic reportMismatch(input string field, input wordT expected, input wordT actual);
        errorCount++;
        $display("FAIL %s %s: expected %h actual %h", testName, field, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Error in %s: %s", testName, what);
    endtask

    instrCheck: assert property (@(posedge clk) disable iff (!arstN) instrMem == expInstr)
        else reportMismatch("instrMem", $sampled(expInstr), $sampled(instrMem));
    pcCheck: assert property (@(posedge clk) disable iff (!arstN) pcMem == expPc)
        else reportMismatch("pcMem", $sampled(expPc), $sampled(pcMem));
    aluCheck: assert property (@(posedge clk) disable iff (!arstN) aluOutMem == expAlu)
        else reportMismatch("aluOutMem", $sampled(expAlu), $sampled(aluOutMem));
    storeCheck: assert property (@(posedge clk) disable iff (!arstN) memWriteDataMem == expStore)
        else reportMismatch("memWriteDataMem", $sampled(expStore), $sampled(memWriteDataMem));
    wbDataCheck: assert property (@(posedge clk) disable iff (!arstN) regWriteDataMem == expWbData)
        else reportMismatch("regWriteDataMem", $sampled(expWbData), $sampled(regWriteDataMem));
    addrRtCheck: assert property (@(posedge clk) disable iff (!arstN) addrRtMem == expAddrRt)
        else reportMismatch("addrRtMem", $sampled(expAddrRt), $sampled(addrRtMem));
    wbAddrCheck: assert property (@(posedge clk) disable iff (!arstN) regWriteAddrMem == expWbAddr)
        else reportMismatch("regWriteAddrMem", $sampled(expWbAddr), $sampled(regWriteAddrMem));
    tnewCheck: assert property (@(posedge clk) disable iff (!arstN) tnewMem == expTnew)
        else reportMismatch("tnewMem", $sampled(expTnew), $sampled(tnewMem));

    resetZero: assert property (@(posedge clk) !arstN |-> (instrMem == NOP && pcMem == '0 &&
            aluOutMem == '0 && memWriteDataMem == '0 && regWriteDataMem == '0 &&
            addrRtMem == '0 && regWriteAddrMem == '0 && tnewMem == '0))
        else reportFailure("outputs not zero while arstN is low");
    holdCheck: assert property (@(posedge clk) disable iff (!arstN) (stall && !clr) |=>
            ($stable(instrMem) && $stable(pcMem) && $stable(aluOutMem) &&
             $stable(memWriteDataMem) && $stable(regWriteDataMem) && $stable(tnewMem) &&
             $stable(addrRtMem) && $stable(regWriteAddrMem)))
        else reportFailure("outputs changed during a stall");
    clrCheck: assert property (@(posedge clk) disable iff (!arstN) clr |=>
            (instrMem == NOP && pcMem == '0 && aluOutMem == '0 && tnewMem == '0 &&
             memWriteDataMem == '0 && regWriteDataMem == '0 &&
             addrRtMem == '0 && regWriteAddrMem == '0))
        else reportFailure("outputs not cleared after clr");

    // One instruction per call, remaining fields random
    task automatic issue(input instrT instr, input wordT rsVal, input wordT rtVal,
                         input bit forwarding);
        @(posedge clk);
        instrEx        <= instr;
        pcEx           <= nextPc;
        dataRsEx       <= rsVal;
        dataRtEx       <= rtVal;
        imm16Ex        <= imm16T'($urandom);
        shamtEx        <= shamtT'($urandom);
        regWriteDataEx <= $urandom;
        regWriteAddrEx <= regAddrT'($urandom);
        tnewEx         <= tnewT'($urandom);
        regDataMem     <= $urandom;
        regDataWb      <= $urandom;
        if (forwarding) begin
            // Small address range so matches are frequent
            addrRsEx   <= regAddrT'($urandom_range(3));
            addrRtEx   <= regAddrT'($urandom_range(3));
            regAddrMem <= regAddrT'($urandom_range(3));
            regAddrWb  <= regAddrT'($urandom_range(3));
        end else begin
            addrRsEx   <= regAddrT'($urandom);
            addrRtEx   <= regAddrT'($urandom);
            regAddrMem <= '0;
            regAddrWb  <= '0;
        end
        lastPc = nextPc;
        nextPc = nextPc + 32'd4;
    endtask

    task automatic waitForPc(input wordT pc);
        int cycles;
        cycles = 0;
        while (pcMem !== pc && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pcMem !== pc)
            reportFailure($sformatf("timeout waiting for pc %h to reach pcMem", pc));
    endtask

    task automatic endTest(input int startErrors);
        waitForPc(lastPc);
        // Let the checks of this edge run before counting
        @(posedge clk);
        if (errorCount == startErrors) begin
            testsPassed++;
            $display("%s: ok", testName);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", testName, errorCount - startErrors);
        end
    endtask

    initial begin
        int start;
        void'($urandom(15));
        errorCount     = 0;
        testsPassed    = 0;
        testsFailed    = 0;
        nextPc         = 32'h0040_0000;
        lastPc         = '0;
        testName       = "init";
        arstN          = 1'b1;
        stall          = 1'b0;
        clr            = 1'b0;
        instrEx        = NOP;
        pcEx           = '0;
        dataRsEx       = $urandom;
        dataRtEx       = $urandom;
        imm16Ex        = '0;
        shamtEx        = '0;
        addrRsEx       = '0;
        addrRtEx       = '0;
        regWriteAddrEx = '0;
        regWriteDataEx = $urandom;
        tnewEx         = '0;
        regAddrMem     = '0;
        regDataMem     = '0;
        regAddrWb      = '0;
        regDataWb      = '0;
        #10 arstN = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;

        testName = "rtype";
        start = errorCount;
        issue(SLT, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        issue(SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        for (int i = 0; i < 40; i++)
            issue(instrT'($urandom_range(SLTU, ADD)), $urandom, $urandom, 1'b0);
        endTest(start);

        testName = "immediate";
        start = errorCount;
        for (int i = 0; i < 40; i++)
            issue(instrT'($urandom_range(SW, ADDI)), $urandom, $urandom, 1'b0);
        endTest(start);

        testName = "shift";
        start = errorCount;
        for (int i = 0; i < 40; i++)
            issue(instrT'($urandom_range(SRAV, SLL)), $urandom,
                  $urandom | (i[0] ? 32'h8000_0000 : 32'h0), 1'b0);
        endTest(start);

        testName = "forward";
        start = errorCount;
        for (int i = 0; i < 40; i++)
            issue(instrT'($urandom_range(SW, ADD)), $urandom, $urandom, 1'b1);
        endTest(start);

        testName = "control";
        start = errorCount;
        issue(ADD, $urandom, $urandom, 1'b0);
        // Next instruction waits at the inputs while the stage holds
        issue(XOR, $urandom, $urandom, 1'b0);
        stall <= 1'b1;
        repeat ($urandom_range(4, 1)) @(posedge clk);
        stall <= 1'b0;
        // Flush while stalled
        @(posedge clk);
        stall <= 1'b1;
        clr   <= 1'b1;
        @(posedge clk);
        clr   <= 1'b0;
        stall <= 1'b0;
        issue(ORI, $urandom, $urandom, 1'b0);
        // Reset in the middle of traffic
        @(posedge clk);
        arstN <= 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        for (int i = 0; i < 12; i++)
            issue(instrT'($urandom_range(J, NOP)), $urandom, $urandom, 1'b1);
        endTest(start);

        testName = "passthrough";
        start = errorCount;
        issue(BEQ, $urandom, $urandom, 1'b0);
        issue(J, $urandom, $urandom, 1'b0);
        issue(NOP, $urandom, $urandom, 1'b0);
        for (int i = 0; i < 24; i++)
            issue(instrT'($urandom_range(J, NOP)), $urandom, $urandom, 1'b0);
        endTest(start);

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errorCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- hw/exStage.sv
/*
 * Execute stage top level
 * Decode, operand bypass, ALU and EX/MEM register
 */

module exStage import exPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    clr,
    input  instrT   instrEx,
    input  wordT    pcEx,
    input  wordT    dataRsEx,
    input  wordT    dataRtEx,
    input  imm16T   imm16Ex,
    input  shamtT   shamtEx,
    input  regAddrT addrRsEx,
    input  regAddrT addrRtEx,
    input  regAddrT regWriteAddrEx,
    input  wordT    regWriteDataEx,
    input  tnewT    tnewEx,
    input  regAddrT regAddrMem,
    input  wordT    regDataMem,
    input  regAddrT regAddrWb,
    input  wordT    regDataWb,
    output instrT   instrMem,
    output wordT    pcMem,
    output wordT    aluOutMem,
    output wordT    memWriteDataMem,
    output regAddrT addrRtMem,
    output regAddrT regWriteAddrMem,
    output wordT    regWriteDataMem,
    output tnewT    tnewMem
);

    aluOpT aluOp;
    logic  signExt;
    logic  useImm;
    logic  shiftByShamt;
    logic  writesAlu;
    wordT  srcRs;
    wordT  srcRt;
    wordT  aluOut;

    // Format and class stay internal to the decoder here
    instrDecode decode (
        .instr        (instrEx),
        .format       (),
        .func         (),
        .aluOp        (aluOp),
        .signExt      (signExt),
        .useImm       (useImm),
        .shiftByShamt (shiftByShamt),
        .writesAlu    (writesAlu)
    );

    operandForward forward (
        .addrRs     (addrRsEx),
        .addrRt     (addrRtEx),
        .regAddrMem (regAddrMem),
        .regAddrWb  (regAddrWb),
        .dataRs     (dataRsEx),
        .dataRt     (dataRtEx),
        .regDataMem (regDataMem),
        .regDataWb  (regDataWb),
        .srcRs      (srcRs),
        .srcRt      (srcRt)
    );

    aluExecute alu (
        .srcRs        (srcRs),
        .srcRt        (srcRt),
        .imm16        (imm16Ex),
        .shamt        (shamtEx),
        .aluOp        (aluOp),
        .signExt      (signExt),
        .useImm       (useImm),
        .shiftByShamt (shiftByShamt),
        .aluOut       (aluOut)
    );

    // Store data is the bypassed Rt
    exResultRegister result (
        .clk             (clk),
        .arstN           (arstN),
        .stall           (stall),
        .clr             (clr),
        .instr           (instrEx),
        .pc              (pcEx),
        .aluOut          (aluOut),
        .storeData       (srcRt),
        .regWriteDataIn  (regWriteDataEx),
        .addrRt          (addrRtEx),
        .regWriteAddr    (regWriteAddrEx),
        .tnewIn          (tnewEx),
        .writesAlu       (writesAlu),
        .instrMem        (instrMem),
        .pcMem           (pcMem),
        .aluOutMem       (aluOutMem),
        .memWriteDataMem (memWriteDataMem),
        .regWriteDataMem (regWriteDataMem),
        .addrRtMem       (addrRtMem),
        .regWriteAddrMem (regWriteAddrMem),
        .tnewMem         (tnewMem)
    );

endmodule

//--- hw/exResultRegister.sv
/*
 * Write-back data select and Tnew countdown
 * EX/MEM pipeline register with clear and hold
 */

module exResultRegister import exPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    clr,
    input  instrT   instr,
    input  wordT    pc,
    input  wordT    aluOut,
    input  wordT    storeData,
    input  wordT    regWriteDataIn,
    input  regAddrT addrRt,
    input  regAddrT regWriteAddr,
    input  tnewT    tnewIn,
    input  logic    writesAlu,
    output instrT   instrMem,
    output wordT    pcMem,
    output wordT    aluOutMem,
    output wordT    memWriteDataMem,
    output wordT    regWriteDataMem,
    output regAddrT addrRtMem,
    output regAddrT regWriteAddrMem,
    output tnewT    tnewMem
);

    wordT regWriteData;
    tnewT tnewNext;

    // Non-ALU instructions keep the value produced upstream
    assign regWriteData = writesAlu ? aluOut : regWriteDataIn;

    // One stage closer to ready, floor at zero
    assign tnewNext = (tnewIn == '0) ? '0 : tnewT'(tnewIn - 1'b1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrMem        <= NOP;
            pcMem           <= '0;
            aluOutMem       <= '0;
            memWriteDataMem <= '0;
            regWriteDataMem <= '0;
            addrRtMem       <= '0;
            regWriteAddrMem <= '0;
            tnewMem         <= '0;
        end else if (clr) begin
            // Flush wins over hold
            instrMem        <= NOP;
            pcMem           <= '0;
            aluOutMem       <= '0;
            memWriteDataMem <= '0;
            regWriteDataMem <= '0;
            addrRtMem       <= '0;
            regWriteAddrMem <= '0;
            tnewMem         <= '0;
        end else if (!stall) begin
            instrMem        <= instr;
            pcMem           <= pc;
            aluOutMem       <= aluOut;
            memWriteDataMem <= storeData;
            regWriteDataMem <= regWriteData;
            addrRtMem       <= addrRt;
            regWriteAddrMem <= regWriteAddr;
            tnewMem         <= tnewNext;
        end
    end

    clrGivesNop: assert property (@(posedge clk) disable iff (!arstN)
        clr |=> (instrMem == NOP))
        else $error("instrMem not NOP after clear");

    stallHolds: assert property (@(posedge clk) disable iff (!arstN)
        (stall && !clr) |=> ($stable(instrMem) && $stable(pcMem) && $stable(aluOutMem) &&
                             $stable(memWriteDataMem) && $stable(regWriteDataMem) &&
                             $stable(addrRtMem) && $stable(regWriteAddrMem) &&
                             $stable(tnewMem)))
        else $error("EX/MEM register changed during stall");

endmodule

//--- hw/aluExecute.sv
/*
 * ALU for the execute stage
 * Immediate extension, source selection and operation table
 */

module aluExecute import exPkg::*; (
    input  wordT   srcRs,
    input  wordT   srcRt,
    input  imm16T  imm16,
    input  shamtT  shamt,
    input  aluOpT  aluOp,
    input  logic   signExt,
    input  logic   useImm,
    input  logic   shiftByShamt,
    output wordT   aluOut
);

    wordT extImm;
    wordT opA;
    wordT opB;

    assign extImm = signExt ? {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16}
                            : {{(WORD_W-IMM_W){1'b0}}, imm16};

    // Fixed shifts take the amount from the instruction field
    assign opA = shiftByShamt ? {{(WORD_W-SHAMT_W){1'b0}}, shamt} : srcRs;
    assign opB = useImm ? extImm : srcRt;

    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                aluOut = opA + opB;
            end
            ALU_SUB: begin
                aluOut = opA - opB;
            end
            ALU_AND: begin
                aluOut = opA & opB;
            end
            ALU_OR: begin
                aluOut = opA | opB;
            end
            ALU_XOR: begin
                aluOut = opA ^ opB;
            end
            ALU_NOR: begin
                aluOut = ~(opA | opB);
            end
            ALU_SLT: begin
                aluOut = ($signed(opA) < $signed(opB)) ? wordT'(1) : '0;
            end
            ALU_SLTU: begin
                aluOut = (opA < opB) ? wordT'(1) : '0;
            end
            // Shifts move B by the low bits of A
            ALU_SLL: begin
                aluOut = opB << opA[SHAMT_W-1:0];
            end
            ALU_SRL: begin
                aluOut = opB >> opA[SHAMT_W-1:0];
            end
            ALU_SRA: begin
                aluOut = wordT'($signed(opB) >>> opA[SHAMT_W-1:0]);
            end
            ALU_LUI: begin
                aluOut = {opB[IMM_W-1:0], {IMM_W{1'b0}}};
            end
            default: begin
                aluOut = '0;
            end
        endcase
    end

endmodule

//--- hw/operandForward.sv
/*
 * Operand bypass for Rs and Rt
 * MEM result first, then WB result, then register file value
 */

module operandForward import exPkg::*; (
    input  regAddrT addrRs,
    input  regAddrT addrRt,
    input  regAddrT regAddrMem,
    input  regAddrT regAddrWb,
    input  wordT    dataRs,
    input  wordT    dataRt,
    input  wordT    regDataMem,
    input  wordT    regDataWb,
    output wordT    srcRs,
    output wordT    srcRt
);

    logic rsFromMem;
    logic rsFromWb;
    logic rtFromMem;
    logic rtFromWb;

    // Register 0 is hardwired, never bypass it
    assign rsFromMem = (regAddrMem == addrRs) && (regAddrMem != '0);
    assign rsFromWb  = (regAddrWb == addrRs) && (regAddrWb != '0);
    assign rtFromMem = (regAddrMem == addrRt) && (regAddrMem != '0);
    assign rtFromWb  = (regAddrWb == addrRt) && (regAddrWb != '0);

    // Older WB loses to the newer MEM value
    assign srcRs = rsFromMem ? regDataMem :
                   rsFromWb  ? regDataWb  : dataRs;
    assign srcRt = rtFromMem ? regDataMem :
                   rtFromWb  ? regDataWb  : dataRt;

    always_comb begin
        assert final (((addrRs != '0) || (srcRs == dataRs)) &&
                      ((addrRt != '0) || (srcRt == dataRt)))
            else $error("bypass value selected for register 0");
    end

endmodule

//--- hw/instrDecode.sv
/*
 * Instruction classifier for the execute stage
 * Format, class, ALU operation and immediate handling per identifier
 */

module instrDecode import exPkg::*; (
    input  instrT  instr,
    output formatT format,
    output funcT   func,
    output aluOpT  aluOp,
    output logic   signExt,
    output logic   useImm,
    output logic   shiftByShamt,
    output logic   writesAlu
);

    // Format and class
    always_comb begin
        format = FORMAT_R;
        func   = FUNC_NONE;
        case (instr)
            ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
            SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                format = FORMAT_R;
                func   = FUNC_CALC_R;
            end
            ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI: begin
                format = FORMAT_I;
                func   = FUNC_CALC_I;
            end
            LW: begin
                format = FORMAT_I;
                func   = FUNC_MEM_READ;
            end
            SW: begin
                format = FORMAT_I;
                func   = FUNC_MEM_WRITE;
            end
            BEQ: begin
                format = FORMAT_I;
                func   = FUNC_BRANCH;
            end
            J: begin
                format = FORMAT_J;
                func   = FUNC_JUMP;
            end
            default: begin
                format = FORMAT_R;
                func   = FUNC_NONE;
            end
        endcase
    end

    // ALU operation, address calculation for loads and stores
    always_comb begin
        case (instr)
            ADD, ADDU, ADDI, ADDIU, LW, SW: aluOp = ALU_ADD;
            SUB, SUBU:                      aluOp = ALU_SUB;
            AND, ANDI:                      aluOp = ALU_AND;
            OR, ORI:                        aluOp = ALU_OR;
            XOR, XORI:                      aluOp = ALU_XOR;
            NOR:                            aluOp = ALU_NOR;
            SLT, SLTI:                      aluOp = ALU_SLT;
            SLTU, SLTIU:                    aluOp = ALU_SLTU;
            SLL, SLLV:                      aluOp = ALU_SLL;
            SRL, SRLV:                      aluOp = ALU_SRL;
            SRA, SRAV:                      aluOp = ALU_SRA;
            LUI:                            aluOp = ALU_LUI;
            default:                        aluOp = ALU_ZERO;
        endcase
    end

    // Logical immediates and LUI take the raw 16 bits
    assign signExt      = !(instr inside {ANDI, ORI, XORI, LUI});
    assign useImm       = (format == FORMAT_I);
    assign shiftByShamt = (instr inside {SLL, SRL, SRA});
    assign writesAlu    = (func == FUNC_CALC_R) || (func == FUNC_CALC_I);

    // Every calculation must map to a real ALU operation
    always_comb begin
        assert final (!writesAlu || (aluOp != ALU_ZERO))
            else $error("calculation %s decoded to ALU_ZERO", instr.name());
    end

endmodule

//--- hw/exPkg.sv
/*
 * Shared widths and data types for the execute stage
 * Instruction identifiers, formats, classes and ALU operation encodings
 */

package exPkg;

    // Data path widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;

    // Largest Tnew any instruction can carry into EX
    localparam int TNEW_MAX   = 3;

    typedef logic [WORD_W-1:0]                wordT;
    typedef logic [REG_ADDR_W-1:0]            regAddrT;
    typedef logic [IMM_W-1:0]                 imm16T;
    typedef logic [SHAMT_W-1:0]               shamtT;
    typedef logic [$clog2(TNEW_MAX+1)-1:0]    tnewT;

    // Decoded instruction identifiers
    typedef enum logic [5:0] {
        NOP,
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        SLLV,
        SRLV,
        SRAV,
        ADDI,
        ADDIU,
        ANDI,
        ORI,
        XORI,
        SLTI,
        SLTIU,
        LUI,
        LW,
        SW,
        BEQ,
        J
    } instrT;

    typedef enum logic [1:0] {
        FORMAT_R,
        FORMAT_I,
        FORMAT_J
    } formatT;

    // Instruction classes as seen by forwarding and write-back
    typedef enum logic [2:0] {
        FUNC_CALC_R,
        FUNC_CALC_I,
        FUNC_MEM_READ,
        FUNC_MEM_WRITE,
        FUNC_BRANCH,
        FUNC_JUMP,
        FUNC_NONE
    } funcT;

    typedef enum logic [3:0] {
        ALU_ZERO,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOpT;

endpackage
